//--- include/edge_shim_defs.svh
// Shared sizing macros for the write edge shim, included by the package and the RTL modules
`ifndef EDGE_SHIM_DEFS_SVH
`define EDGE_SHIM_DEFS_SVH

// ==================================================
// Write-data heap
// ==================================================

// Number of write-data slots parked at the edge
`define EDGE_HEAP_ENTRIES 16

// ==================================================
// Request fields
// ==================================================

// Width of one cache-line data beat
`define EDGE_LINE_BITS 64

// Width of the cache-line address
`define EDGE_ADDR_BITS 16

// Beats a sender may still issue after it sees almost-full
`define EDGE_ALM_FULL_THRESHOLD 4

`endif

//--- src/edge_shim_pkg.sv
// Request types for the write edge shim, imported by every module that carries write beats
`default_nettype none

`include "edge_shim_defs.svh"

package edge_shim_pkg;

    // Beat count code of a write packet
    // 0 means 1 beat, 1 means 2 beats and 3 means 4 beats, so the code is beats minus one
    typedef logic [1:0] cl_len_t;

    // Code of a single-beat write
    localparam cl_len_t CL_LEN_1 = 2'b00;

    // Index of one slot in the write-data heap
    typedef logic [$clog2(`EDGE_HEAP_ENTRIES)-1:0] heap_idx_t;

    // One cache-line data beat
    typedef logic [`EDGE_LINE_BITS-1:0] line_data_t;

    // One write beat on either edge
    // Inside the shim pipeline the low bits of data carry the heap slot of the sop beat
    typedef struct packed {
        logic                       valid;
        logic                       sop;
        cl_len_t                    cl_len;
        logic [`EDGE_ADDR_BITS-1:0] addr;
        line_data_t                 data;
    } wr_req_t;

endpackage

`default_nettype wire

//--- src/write_data_heap.sv
// Slot storage for write-data beats, filled in ring order at the AFU edge and read at the FIU edge
`default_nettype none
`timescale 1ns/1ps

`include "edge_shim_defs.svh"

module write_data_heap
#(
    parameter int N_ENTRIES = `EDGE_HEAP_ENTRIES
)
(
    input  logic                   clk,
    input  logic                   reset,

    // Store one beat at the next sequential slot
    input  logic                   enq,
    input  edge_shim_pkg::line_data_t enq_data,
    output logic                   not_full,
    output edge_shim_pkg::heap_idx_t  alloc_idx,

    // Registered read port, data follows the index by one cycle
    input  edge_shim_pkg::heap_idx_t  read_idx,
    output edge_shim_pkg::line_data_t read_data,

    // Return one slot
    input  logic                   free,
    input  edge_shim_pkg::heap_idx_t  free_idx
);

    import edge_shim_pkg::*;

    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Slots that must stay free so a sender that sees not_full low can still finish
    localparam logic [CNT_BITS-1:0] MIN_FREE = CNT_BITS'(`EDGE_ALM_FULL_THRESHOLD + 1);

    line_data_t            mem [N_ENTRIES];
    logic [N_ENTRIES-1:0]  live;
    logic [CNT_BITS-1:0]   free_cnt;
    logic                  free_ok;

    // A slot returns to the pool only if it currently holds a beat
    assign free_ok  = free && live[free_idx];
    assign not_full = (free_cnt >= MIN_FREE);

    // ==================================================
    // Storage and read port
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[alloc_idx] <= enq_data;
        end

        read_data <= mem[read_idx];
    end

    // ==================================================
    // Allocation and free tracking
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alloc_idx <= '0;
            live      <= '0;
            free_cnt  <= CNT_BITS'(N_ENTRIES);
        end
        else
        begin
            // Slots are handed out in ring order, so one packet's beats sit side by side
            if (enq)
            begin
                alloc_idx       <= alloc_idx + 1'b1;
                live[alloc_idx] <= 1'b1;
            end

            if (free_ok)
            begin
                live[free_idx] <= 1'b0;
            end

            case ({enq, free_ok})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/req_fifo.sv
// Ring-buffer FIFO for request headers, used as the pipeline stand-in and as the edge header buffer
`default_nettype none
`timescale 1ns/1ps

`include "edge_shim_defs.svh"

module req_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  N_ENTRIES = 8
)
(
    input  logic     clk,
    input  logic     reset,

    input  logic     enq,
    input  payload_t enq_data,
    output logic     alm_full,

    output payload_t first,
    output logic     not_empty,
    input  logic     deq
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Occupancy at which the sender is told to stop
    localparam logic [CNT_BITS-1:0] ALM_LEVEL =
        CNT_BITS'(N_ENTRIES - `EDGE_ALM_FULL_THRESHOLD);

    payload_t            mem [N_ENTRIES];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Step a pointer around the ring, which need not be a power of two deep
    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
        ptr_next = (ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign alm_full  = (count >= ALM_LEVEL);

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end

            if (deq)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end

            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/write_edge_connect.sv
// Write edge block that parks write data in a heap on entry and rebuilds every beat on exit
`default_nettype none
`timescale 1ns/1ps

`include "edge_shim_defs.svh"

module write_edge_connect
(
    input  logic                    clk,
    input  logic                    reset,

    // AFU side
    input  edge_shim_pkg::wr_req_t  afu_req,
    output logic                    afu_alm_full,

    // Entry of the shim pipeline
    output edge_shim_pkg::wr_req_t  pipe_in,
    input  logic                    pipe_alm_full,

    // Exit of the shim pipeline
    input  edge_shim_pkg::wr_req_t  pipe_first,
    input  logic                    pipe_not_empty,
    output logic                    pipe_deq,

    // FIU side
    output edge_shim_pkg::wr_req_t  fiu_req,
    input  logic                    fiu_alm_full
);

    import edge_shim_pkg::*;

    localparam int OUT_FIFO_ENTRIES = `EDGE_ALM_FULL_THRESHOLD + 2;

    logic       heap_not_full;
    heap_idx_t  heap_alloc_idx;
    line_data_t heap_rd_data;

    wr_req_t    out_first;
    logic       out_not_empty;
    logic       out_deq;
    logic       out_alm_full;

    // Stages 2 and 3 carry the heap slot in the data field of the request
    wr_req_t    stg1_req;
    wr_req_t    stg2_req;
    wr_req_t    stg3_req;
    logic       stg1_sop;
    cl_len_t    stg1_beats_rem;
    heap_idx_t  stg1_idx;
    logic       stg1_data_rdy;

    logic       fire;
    logic       packet_done;

    // Every beat is stored here
    // Stage 2 reads the slot of its beat and stage 3 gives the slot back
    write_data_heap #(
        .N_ENTRIES (`EDGE_HEAP_ENTRIES)
    ) heap_i (
        .clk       (clk),
        .reset     (reset),
        .enq       (afu_req.valid),
        .enq_data  (afu_req.data),
        .not_full  (heap_not_full),
        .alloc_idx (heap_alloc_idx),
        .read_idx  (heap_idx_t'(stg2_req.data)),
        .read_data (heap_rd_data),
        .free      (stg3_req.valid),
        .free_idx  (heap_idx_t'(stg3_req.data))
    );

    // ==================================================
    // AFU edge
    // ==================================================

    assign afu_alm_full = pipe_alm_full || !heap_not_full;

    always_comb
    begin
        pipe_in = afu_req;
        // The data now lives in the heap, so only its slot travels on
        pipe_in.data = line_data_t'(heap_alloc_idx);
        // Only the sop beat enters the pipeline and the rest are rebuilt at the exit
        pipe_in.valid = afu_req.valid && (afu_req.sop || (afu_req.cl_len == CL_LEN_1));
    end

    // ==================================================
    // FIU edge
    // ==================================================

    // Headers leave the pipeline into a local buffer, since the exit stalls on long packets
    assign pipe_deq = pipe_not_empty && !out_alm_full;

    req_fifo #(
        .payload_t (wr_req_t),
        .N_ENTRIES (OUT_FIFO_ENTRIES)
    ) out_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .enq       (pipe_deq),
        .enq_data  (pipe_first),
        .alm_full  (out_alm_full),
        .first     (out_first),
        .not_empty (out_not_empty),
        .deq       (out_deq)
    );

    always_comb
    begin
        // Ready data implies stage 1 holds a valid header
        fire        = !fiu_alm_full && stg1_data_rdy;
        packet_done = fire && (stg1_beats_rem == '0);
        // Load a header when stage 1 is idle or its last beat goes this cycle
        out_deq     = out_not_empty && (packet_done || !stg1_req.valid);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg1_req       <= '0;
            stg1_sop       <= 1'b1;
            stg1_beats_rem <= '0;
            stg1_idx       <= '0;
            stg1_data_rdy  <= 1'b0;
            stg2_req       <= '0;
            stg3_req       <= '0;
        end
        else
        begin
            if (out_deq)
            begin
                stg1_req       <= out_first;
                stg1_sop       <= 1'b1;
                stg1_beats_rem <= out_first.cl_len;
                stg1_idx       <= heap_idx_t'(out_first.data);
                // The sop slot was written before its header entered the pipeline
                stg1_data_rdy  <= out_first.valid;
            end
            else if (packet_done)
            begin
                stg1_req.valid <= 1'b0;
                stg1_data_rdy  <= 1'b0;
            end
            else if (fire)
            begin
                // In the middle of a packet the next beat sits in the next consecutive slot
                stg1_sop       <= 1'b0;
                stg1_beats_rem <= stg1_beats_rem - 1'b1;
                stg1_idx       <= stg1_idx + 1'b1;
                stg1_data_rdy  <= ((stg1_idx + 1'b1) != heap_alloc_idx);
            end
            else
            begin
                // Wait until the AFU has written the slot
                stg1_data_rdy  <= stg1_req.valid && (stg1_idx != heap_alloc_idx);
            end

            if (fire)
            begin
                stg2_req      <= stg1_req;
                stg2_req.sop  <= stg1_sop;
                stg2_req.data <= line_data_t'(stg1_idx);
            end
            else
            begin
                stg2_req.valid <= 1'b0;
            end

            stg3_req <= stg2_req;
        end
    end

    // The registered heap read lines up with stage 3
    always_comb
    begin
        fiu_req      = stg3_req;
        fiu_req.data = heap_rd_data;
    end

endmodule

`default_nettype wire

//--- src/edge_shim_top.sv
// Top level of the write edge shim, closing the pipeline between the AFU and FIU edges with a FIFO
`default_nettype none
`timescale 1ns/1ps

`include "edge_shim_defs.svh"

module edge_shim_top
(
    input  logic                   clk,
    input  logic                   reset,

    // AFU side
    input  edge_shim_pkg::wr_req_t afu_req,
    output logic                   afu_alm_full,

    // FIU side
    output edge_shim_pkg::wr_req_t fiu_req,
    input  logic                   fiu_alm_full
);

    import edge_shim_pkg::*;

    // Depth of the FIFO that stands in for the rest of the shim pipeline
    localparam int PIPE_ENTRIES = 2 * `EDGE_ALM_FULL_THRESHOLD;

    wr_req_t pipe_in;
    logic    pipe_alm_full;
    wr_req_t pipe_out;
    logic    pipe_not_empty;
    logic    pipe_deq;

    write_edge_connect edge_i (
        .clk            (clk),
        .reset          (reset),
        .afu_req        (afu_req),
        .afu_alm_full   (afu_alm_full),
        .pipe_in        (pipe_in),
        .pipe_alm_full  (pipe_alm_full),
        .pipe_first     (pipe_out),
        .pipe_not_empty (pipe_not_empty),
        .pipe_deq       (pipe_deq),
        .fiu_req        (fiu_req),
        .fiu_alm_full   (fiu_alm_full)
    );

    // Headers only, each carrying its heap slot instead of data
    req_fifo #(
        .payload_t (wr_req_t),
        .N_ENTRIES (PIPE_ENTRIES)
    ) pipe_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .enq       (pipe_in.valid),
        .enq_data  (pipe_in),
        .alm_full  (pipe_alm_full),
        .first     (pipe_out),
        .not_empty (pipe_not_empty),
        .deq       (pipe_deq)
    );

endmodule

`default_nettype wire

//--- dv/edge_shim_checker.sv
// Testbench checker that queues every AFU write beat and compares the FIU beat stream against it
`default_nettype none
`timescale 1ns/1ps

`include "edge_shim_defs.svh"

module edge_shim_checker
(
    input  logic                   clk,
    input  logic                   reset,
    input  edge_shim_pkg::wr_req_t afu_req,
    input  edge_shim_pkg::wr_req_t fiu_req
);

    import edge_shim_pkg::*;

    // Name of the running test, set by the testbench top
    string   test_name = "reset";
    int      errors    = 0;
    int      beats_in  = 0;
    int      beats_out = 0;

    // Model of the shim: every beat leaves in the order it arrived, unchanged
    wr_req_t exp_q [$];
    wr_req_t exp_beat;

    // Report one field that differs from the model
    task automatic check_field(input string field, input line_data_t expected,
                               input line_data_t actual);
        if (expected !== actual)
        begin
            $display("FAIL %s %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    // ==================================================
    // Sampling at the rising edge
    // ==================================================

    // Inputs change on the falling edge, so both edges are stable here
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (afu_req.valid)
            begin
                exp_q.push_back(afu_req);
                beats_in++;
            end

            if (fiu_req.valid === 1'b1)
            begin
                beats_out++;
                if (exp_q.size() == 0)
                begin
                    $display("Test %s saw an FIU beat with no write outstanding", test_name);
                    errors++;
                end
                else
                begin
                    exp_beat = exp_q.pop_front();
                    check_field("data", exp_beat.data, fiu_req.data);
                    check_field("addr", line_data_t'(exp_beat.addr), line_data_t'(fiu_req.addr));
                    check_field("cl_len", line_data_t'(exp_beat.cl_len),
                                line_data_t'(fiu_req.cl_len));
                    check_field("sop", line_data_t'(exp_beat.sop), line_data_t'(fiu_req.sop));
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/edge_shim_tb.sv
// Testbench top for the write edge shim, driving random write packets and reporting per test
`default_nettype none
`timescale 1ns/1ps

`include "edge_shim_defs.svh"

module edge_shim_tb;

    import edge_shim_pkg::*;

    // Back-pressure modes on the FIU side
    localparam int BP_OFF    = 0;
    localparam int BP_RANDOM = 1;
    localparam int BP_HOLD   = 2;

    // Cycles the AFU side is kept stalled before the FIU side is released
    localparam int HOLD_CYCLES = 50;

    logic        clk;
    logic        reset;
    wr_req_t     afu_req;
    logic        afu_alm_full;
    wr_req_t     fiu_req;
    logic        fiu_alm_full;

    logic [31:0] rng_state = 32'd87514;
    int          bp_mode = BP_OFF;
    int          full_cycles = 0;
    logic        alm_rose = 1'b0;
    int          tb_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    int          cycle_cnt = 0;
    int          n;

    edge_shim_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .afu_req      (afu_req),
        .afu_alm_full (afu_alm_full),
        .fiu_req      (fiu_req),
        .fiu_alm_full (fiu_alm_full)
    );

    edge_shim_checker check_i (
        .clk     (clk),
        .reset   (reset),
        .afu_req (afu_req),
        .fiu_req (fiu_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Packet length of 1, 2 or 4 beats, or only 2 or 4
    function automatic int pick_length(input bit multi_only);
        logic [31:0] r;
        r = rand32();
        if (multi_only)
            return r[0] ? 4 : 2;
        case (r % 32'd3)
            32'd0:   return 1;
            32'd1:   return 2;
            default: return 4;
        endcase
    endfunction

    // Move to the next falling edge, idle the AFU side and update FIU back-pressure
    task automatic step_cycle();
        logic [31:0] r;
        @(negedge clk);
        afu_req = '0;
        case (bp_mode)
            BP_RANDOM:
            begin
                r = rand32();
                if (r[1:0] == 2'b00)
                    fiu_alm_full = !fiu_alm_full;
            end
            BP_HOLD:
            begin
                fiu_alm_full = 1'b1;
                if (afu_alm_full)
                begin
                    alm_rose = 1'b1;
                    full_cycles++;
                end
                // Let the stalled traffic drain once the AFU side has been held off a while
                if (full_cycles >= HOLD_CYCLES)
                begin
                    bp_mode      = BP_OFF;
                    fiu_alm_full = 1'b0;
                end
            end
            default: fiu_alm_full = 1'b0;
        endcase
    endtask

    // One packet: one address, sop on the first beat, fresh data on every beat
    task automatic send_packet(input int beats, input int max_gap);
        logic [31:0] r;
        wr_req_t     beat;
        int          b;
        int          gap;
        r           = rand32();
        beat        = '0;
        beat.valid  = 1'b1;
        beat.cl_len = cl_len_t'(beats - 1);
        beat.addr   = r[`EDGE_ADDR_BITS-1:0];
        for (b = 0; b < beats; b++)
        begin
            beat.sop  = (b == 0);
            beat.data = line_data_t'({rand32(), rand32()});
            r         = rand32();
            gap       = (max_gap > 0) ? int'(r % 32'(max_gap + 1)) : 0;
            repeat (gap) step_cycle();
            // No new beat while the shim asks the AFU to stop
            while (afu_alm_full)
                step_cycle();
            afu_req = beat;
            step_cycle();
        end
    endtask

    // Wait for every accepted beat to come out, then watch a little longer for extras
    task automatic drain_pipeline();
        while (check_i.beats_out < check_i.beats_in)
            step_cycle();
        repeat (20) step_cycle();
    endtask

    task automatic start_test(input string name);
        check_i.test_name = name;
        errors_at_start   = check_i.errors + tb_errors;
    endtask

    task automatic finish_test(input string name);
        int errs;
        if (check_i.beats_out != check_i.beats_in)
        begin
            $display("Test %s ended with %0d beats in but %0d beats out", name,
                     check_i.beats_in, check_i.beats_out);
            tb_errors++;
        end
        errs = check_i.errors + tb_errors - errors_at_start;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %-14s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    // Reset check on the outputs, X counts as wrong
    task automatic check_reset_state();
        if (fiu_req.valid !== 1'b0)
        begin
            $display("FAIL reset fiu_req.valid expected 0 actual %b", fiu_req.valid);
            tb_errors++;
        end
        if (afu_alm_full !== 1'b0)
        begin
            $display("FAIL reset afu_alm_full expected 0 actual %b", afu_alm_full);
            tb_errors++;
        end
    endtask

    // ==================================================
    // Watchdog
    // ==================================================

    // Allows 200 cycles per beat sent, plus slack for reset and the final drain
    initial
    begin
        while (cycle_cnt <= 200 * (check_i.beats_in + 10))
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Watchdog expired after %0d cycles, the shim stopped moving beats", cycle_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        reset        = 1'b1;
        afu_req      = '0;
        fiu_alm_full = 1'b0;

        start_test("reset");
        repeat (2)
        begin
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        finish_test("reset");

        start_test("single_beat");
        for (n = 0; n < 20; n++)
            send_packet(1, 0);
        drain_pipeline();
        finish_test("single_beat");

        start_test("multi_beat");
        for (n = 0; n < 20; n++)
            send_packet(pick_length(1'b1), 3);
        drain_pipeline();
        finish_test("multi_beat");

        start_test("random_bp");
        bp_mode = BP_RANDOM;
        for (n = 0; n < 30; n++)
            send_packet(pick_length(1'b0), 2);
        drain_pipeline();
        bp_mode = BP_OFF;
        finish_test("random_bp");

        // More beats than the heap holds, so the AFU side must be stopped
        start_test("hold_bp");
        full_cycles = 0;
        alm_rose    = 1'b0;
        bp_mode     = BP_HOLD;
        for (n = 0; n < 16; n++)
            send_packet(4, 0);
        drain_pipeline();
        if (!alm_rose)
        begin
            $display("afu_alm_full never rose while the FIU side was held off");
            tb_errors++;
        end
        finish_test("hold_bp");

        $display("%0d tests run, %0d failed, %0d beats in, %0d beats out, %0d errors",
                 tests_run, tests_failed, check_i.beats_in, check_i.beats_out,
                 check_i.errors + tb_errors);
        if (tests_failed == 0 && check_i.errors + tb_errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- edge_shim.f
+incdir+include
src/edge_shim_pkg.sv
src/write_data_heap.sv
src/req_fifo.sv
src/write_edge_connect.sv
src/edge_shim_top.sv
dv/edge_shim_checker.sv
dv/edge_shim_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f edge_shim.f --top-module edge_shim_tb -o edge_shim_sim

sim_out=$(./obj_dir/edge_shim_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
